//--- Makefile
# Verilator build and run of the cornet cpu testbench

.PHONY: test clean help

test:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module tb_cornet_cpu -Mdir obj_dir -f tb.f
	./obj_dir/Vtb_cornet_cpu +verilator+error+limit+100 | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

help:
	@echo "make test   build and run the testbench, fails unless the log shows a pass"
	@echo "make clean  remove build output and the log"
	@echo "make help   list the targets"

//--- rtl/bus_access.sv
// bus unit
// runs byte and word operand reads on the memory port, low byte first,
// performs stores and shares the port with the opcode fetch

module bus_access (
   input  logic                           clk,
   input  logic                           reset_n,
   data_bus_if.unit                       bus,
   input  logic                           fetch_req,
   input  logic                           fetch_hold,
   input  logic [cpu_bus_pkg::ADDR_W-1:0] fetch_addr,
   output logic [cpu_bus_pkg::DATA_W-1:0] fetch_data,
   output logic                           fetch_ack,
   output logic [cpu_bus_pkg::ADDR_W-1:0] addr,
   output logic [cpu_bus_pkg::DATA_W-1:0] wr_data,
   output logic                           wr_en,
   output logic                           rd_req,
   input  logic [cpu_bus_pkg::DATA_W-1:0] rd_data,
   input  logic                           ready
);
   import cpu_bus_pkg::*;

   logic [RD_W-1:0]   rd_state;
   logic [ADDR_W-1:0] bus_addr;
   logic              bus_rd_req;
   logic              rd_start;

   assign rd_start   = bus.rd_byte | bus.rd_word | bus.mem_rd;
   assign rd_req     = fetch_req | bus_rd_req;
   assign addr       = fetch_hold ? fetch_addr : bus_addr;
   assign fetch_data = rd_data;
   assign fetch_ack  = fetch_hold & ready & ~fetch_req;   // ready with the strobe is ignored

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         rd_state   <= RD_IDLE;
         bus_rd_req <= 1'b0;
         bus.ack    <= 1'b0;
         wr_en      <= 1'b0;
      end
      else
      begin
         bus_rd_req <= 1'b0;
         bus.ack    <= 1'b0;
         wr_en      <= 1'b0;
         if (rd_start)
         begin
            bus_addr   <= bus.mem_rd ? bus.mem_addr : bus.rd_addr;
            bus_rd_req <= 1'b1;
            rd_state   <= bus.rd_word ? RD_WORD_L : RD_BYTE;
         end
         else if (bus.wr_en)
         begin
            bus_addr <= bus.wr_addr;
            wr_data  <= bus.wr_data;
            wr_en    <= 1'b1;
         end
         else if (ready && !bus_rd_req)
         begin
            case (rd_state)
               RD_BYTE:
               begin
                  bus.operand.bytes.lo <= rd_data;
                  bus.ack              <= 1'b1;
                  rd_state             <= RD_IDLE;
               end
               RD_WORD_L:
               begin
                  bus.operand.bytes.lo <= rd_data;
                  bus_addr             <= bus_addr + 1'b1;   // high byte follows
                  bus_rd_req           <= 1'b1;
                  rd_state             <= RD_WORD_H;
               end
               RD_WORD_H:
               begin
                  bus.operand.bytes.hi <= rd_data;
                  bus.ack              <= 1'b1;
                  rd_state             <= RD_IDLE;
               end
               default:
                  ;      // ready of an opcode fetch
            endcase
         end
      end
   end

endmodule

//--- rtl/cornet_cpu.sv
// cornet cpu top level
// small 6502 style cpu on one byte wide memory port with read strobe and ready

module cornet_cpu (
   input  logic                           clk,
   input  logic                           reset_n,
   output logic [cpu_bus_pkg::ADDR_W-1:0] addr,
   input  logic [cpu_bus_pkg::DATA_W-1:0] rd_data,
   output logic [cpu_bus_pkg::DATA_W-1:0] wr_data,
   output logic                           wr_en,
   output logic                           rd_req,
   input  logic                           ready
);
   import cpu_bus_pkg::*;
   import cpu_isa_pkg::*;

   logic              start;
   logic              reset_start;
   logic [7:0]        opcode;
   logic [ADDR_W-1:0] pc;
   logic [OP_W-1:0]   op;
   logic [1:0]        pc_delta;
   logic              done;
   logic [ADDR_W-1:0] pc_next;
   logic              flag_z;
   logic              fetch_req;
   logic              fetch_hold;
   logic [ADDR_W-1:0] fetch_addr;
   logic [DATA_W-1:0] fetch_data;
   logic              fetch_ack;

   data_bus_if data_bus ();

   cpu_fetch u_fetch (
      .clk         (clk),
      .reset_n     (reset_n),
      .done        (done),
      .pc_next     (pc_next),
      .fetch_data  (fetch_data),
      .fetch_ack   (fetch_ack),
      .fetch_req   (fetch_req),
      .fetch_hold  (fetch_hold),
      .fetch_addr  (fetch_addr),
      .pc          (pc),
      .opcode      (opcode),
      .start       (start),
      .reset_start (reset_start)
   );

   cpu_decode u_decode (
      .clk         (clk),
      .reset_n     (reset_n),
      .start       (start),
      .reset_start (reset_start),
      .opcode      (opcode),
      .pc          (pc),
      .flag_z      (flag_z),
      .bus         (data_bus.decode),
      .op          (op),
      .pc_delta    (pc_delta)
   );

   cpu_execute u_execute (
      .clk      (clk),
      .reset_n  (reset_n),
      .op       (op),
      .pc_delta (pc_delta),
      .pc       (pc),
      .bus      (data_bus.execute),
      .done     (done),
      .pc_next  (pc_next),
      .flag_z   (flag_z)
   );

   bus_access u_bus (
      .clk        (clk),
      .reset_n    (reset_n),
      .bus        (data_bus.unit),
      .fetch_req  (fetch_req),
      .fetch_hold (fetch_hold),
      .fetch_addr (fetch_addr),
      .fetch_data (fetch_data),
      .fetch_ack  (fetch_ack),
      .addr       (addr),
      .wr_data    (wr_data),
      .wr_en      (wr_en),
      .rd_req     (rd_req),
      .rd_data    (rd_data),
      .ready      (ready)
   );

endmodule

//--- rtl/cpu_bus_pkg.sv
// cornet cpu memory bus definitions
// bus widths, fixed addresses and the read sequencer states of the bus unit

package cpu_bus_pkg;

   localparam int ADDR_W = 16;
   localparam int DATA_W = 8;

   localparam logic [ADDR_W-1:0] RESET_VECTOR = 16'hFFFC;   // low byte of the start address
   localparam logic [DATA_W-1:0] ZERO_PAGE    = 8'h00;      // high byte for zero page operands

   //////////////////////////////
   // bus unit read states
   localparam int RD_W = 2;

   localparam logic [RD_W-1:0] RD_IDLE   = 2'd0;
   localparam logic [RD_W-1:0] RD_BYTE   = 2'd1;
   localparam logic [RD_W-1:0] RD_WORD_L = 2'd2;
   localparam logic [RD_W-1:0] RD_WORD_H = 2'd3;

endpackage

//--- rtl/cpu_decode.sv
// opcode decoder
// maps the fetched opcode to an operation and an instruction length and
// issues the operand read at pc+1, or the word read of the reset vector

module cpu_decode (
   input  logic                           clk,
   input  logic                           reset_n,
   input  logic                           start,
   input  logic                           reset_start,
   input  logic [7:0]                     opcode,
   input  logic [cpu_bus_pkg::ADDR_W-1:0] pc,
   input  logic                           flag_z,
   data_bus_if.decode                     bus,
   output logic [cpu_isa_pkg::OP_W-1:0]   op,
   output logic [1:0]                     pc_delta
);
   import cpu_bus_pkg::*;
   import cpu_isa_pkg::*;

   logic [OP_W-1:0] dec_op;
   logic [1:0]      dec_len;

   always_comb
   begin
      case (opcode)
         OPC_JMP:                 dec_op = OP_JMP;
         OPC_LDA_IMM:             dec_op = OP_LDA;
         OPC_LDX_IMM:             dec_op = OP_LDX;
         OPC_LDY_IMM:             dec_op = OP_LDY;
         OPC_LDA_ZP, OPC_LDA_ABS: dec_op = OP_LDA_MEM;
         OPC_STA_ZP, OPC_STA_ABS: dec_op = OP_STA;
         OPC_INX:                 dec_op = OP_INX;
         OPC_INY:                 dec_op = OP_INY;
         OPC_CMP:                 dec_op = OP_CMP;
         OPC_CPX:                 dec_op = OP_CPX;
         OPC_CPY:                 dec_op = OP_CPY;
         OPC_BNE:                 dec_op = flag_z ? OP_NO_BRANCH : OP_BRANCH;
         OPC_BEQ:                 dec_op = flag_z ? OP_BRANCH : OP_NO_BRANCH;
         default:                 dec_op = OP_NO_BRANCH;   // unknown opcode steps one byte
      endcase
   end

   always_comb
   begin
      case (opcode)
         OPC_JMP, OPC_LDA_ABS, OPC_STA_ABS:
            dec_len = 2'd3;
         OPC_LDA_IMM, OPC_LDX_IMM, OPC_LDY_IMM,
         OPC_LDA_ZP, OPC_STA_ZP,
         OPC_CMP, OPC_CPX, OPC_CPY,
         OPC_BNE, OPC_BEQ:
            dec_len = 2'd2;
         default:
            dec_len = 2'd1;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         op          <= OP_NOP;
         bus.rd_byte <= 1'b0;
         bus.rd_word <= 1'b0;
      end
      else
      begin
         op          <= OP_NOP;              // op is shown to execute for one cycle
         bus.rd_byte <= 1'b0;
         bus.rd_word <= 1'b0;
         if (reset_start)
         begin
            op          <= OP_RESET;
            pc_delta    <= 2'd0;
            bus.rd_word <= 1'b1;
            bus.rd_addr <= RESET_VECTOR;
         end
         else if (start)
         begin
            op          <= dec_op;
            pc_delta    <= dec_len;
            bus.rd_addr <= pc + 1'b1;
            // a branch that is not taken needs no offset
            bus.rd_byte <= (dec_len == 2'd2) && (dec_op != OP_NO_BRANCH);
            bus.rd_word <= (dec_len == 2'd3);
         end
      end
   end

endmodule

//--- rtl/cpu_execute.sv
// execute stage
// holds a, x, y and the z flag, applies each operation once its operand
// has arrived, issues the load read or the store and computes the next pc

module cpu_execute (
   input  logic                           clk,
   input  logic                           reset_n,
   input  logic [cpu_isa_pkg::OP_W-1:0]   op,
   input  logic [1:0]                     pc_delta,
   input  logic [cpu_bus_pkg::ADDR_W-1:0] pc,
   data_bus_if.execute                    bus,
   output logic                           done,
   output logic [cpu_bus_pkg::ADDR_W-1:0] pc_next,
   output logic                           flag_z
);
   import cpu_bus_pkg::*;
   import cpu_isa_pkg::*;

   logic [DATA_W-1:0] reg_a;
   logic [DATA_W-1:0] reg_x;
   logic [DATA_W-1:0] reg_y;
   logic [OP_W-1:0]   cur_op;
   logic              mem_phase;        // load read in flight
   logic              st_phase;         // store issued last cycle
   logic [DATA_W-1:0] byte_in;
   logic [ADDR_W-1:0] pc_step;
   logic [ADDR_W-1:0] op_addr;
   logic [ADDR_W-1:0] target;

   assign byte_in = bus.operand.bytes.lo;
   assign pc_step = pc + ADDR_W'(pc_delta);
   assign op_addr = (pc_delta == 2'd2) ? {ZERO_PAGE, byte_in} : bus.operand.word;

   always_comb
   begin
      case (cur_op)
         OP_RESET, OP_JMP:
            target = bus.operand.word;
         OP_BRANCH:   // offset counts from the byte after the branch
            target = pc + ADDR_W'(2) + {{(ADDR_W-DATA_W){byte_in[DATA_W-1]}}, byte_in};
         default:
            target = pc_step;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         done       <= 1'b0;
         bus.mem_rd <= 1'b0;
         bus.wr_en  <= 1'b0;
         cur_op     <= OP_NOP;
         mem_phase  <= 1'b0;
         st_phase   <= 1'b0;
         flag_z     <= 1'b0;
      end
      else
      begin
         done       <= 1'b0;
         bus.mem_rd <= 1'b0;
         bus.wr_en  <= 1'b0;
         if (op != OP_NOP)
         begin
            cur_op    <= op;
            mem_phase <= 1'b0;
            st_phase  <= 1'b0;
            // ops without an operand finish at once
            case (op)
               OP_INX:
               begin
                  reg_x   <= reg_x + 1'b1;
                  flag_z  <= (reg_x == '1);
                  pc_next <= pc_step;
                  done    <= 1'b1;
               end
               OP_INY:
               begin
                  reg_y   <= reg_y + 1'b1;
                  flag_z  <= (reg_y == '1);
                  pc_next <= pc_step;
                  done    <= 1'b1;
               end
               OP_NO_BRANCH:
               begin
                  pc_next <= pc_step;
                  done    <= 1'b1;
               end
               default:
                  ;
            endcase
         end
         else if (bus.ack && !mem_phase && (cur_op == OP_LDA_MEM))
         begin
            bus.mem_rd   <= 1'b1;
            bus.mem_addr <= op_addr;
            mem_phase    <= 1'b1;
         end
         else if (bus.ack && (cur_op == OP_STA))
         begin
            bus.wr_en   <= 1'b1;
            bus.wr_addr <= op_addr;
            bus.wr_data <= reg_a;
            st_phase    <= 1'b1;
         end
         else if (bus.ack || st_phase)
         begin
            mem_phase <= 1'b0;
            st_phase  <= 1'b0;
            pc_next   <= target;
            done      <= 1'b1;
            case (cur_op)
               OP_RESET:
               begin
                  reg_a <= '0;
                  reg_x <= '0;
                  reg_y <= '0;
               end
               OP_LDA, OP_LDA_MEM:
               begin
                  reg_a  <= byte_in;
                  flag_z <= (byte_in == '0);
               end
               OP_LDX:
               begin
                  reg_x  <= byte_in;
                  flag_z <= (byte_in == '0);
               end
               OP_LDY:
               begin
                  reg_y  <= byte_in;
                  flag_z <= (byte_in == '0);
               end
               OP_CMP: flag_z <= (reg_a == byte_in);
               OP_CPX: flag_z <= (reg_x == byte_in);
               OP_CPY: flag_z <= (reg_y == byte_in);
               default:
                  ;
            endcase
         end
      end
   end

endmodule

//--- rtl/cpu_fetch.sv
// instruction sequencer
// runs the reset vector load once, then fetches one opcode at a time
// and waits for execute to finish before moving the pc

module cpu_fetch (
   input  logic                           clk,
   input  logic                           reset_n,
   input  logic                           done,
   input  logic [cpu_bus_pkg::ADDR_W-1:0] pc_next,
   input  logic [7:0]                     fetch_data,
   input  logic                           fetch_ack,
   output logic                           fetch_req,
   output logic                           fetch_hold,
   output logic [cpu_bus_pkg::ADDR_W-1:0] fetch_addr,
   output logic [cpu_bus_pkg::ADDR_W-1:0] pc,
   output logic [7:0]                     opcode,
   output logic                           start,
   output logic                           reset_start
);
   import cpu_isa_pkg::*;

   logic [FS_W-1:0] state;

   assign fetch_req   = (state == FS_FETCH);
   assign fetch_hold  = (state == FS_FETCH) || (state == FS_LOAD);   // port address follows pc
   assign fetch_addr  = pc;
   assign start       = (state == FS_EXECUTE);
   assign reset_start = (state == FS_RESET);

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         state <= FS_WAIT;
      end
      else
      begin
         case (state)
            FS_WAIT:
               state <= FS_RESET;
            FS_RESET:
               state <= FS_EXEC_WAIT;         // vector load ends like an instruction
            FS_FETCH:
               state <= FS_LOAD;
            FS_LOAD:
               if (fetch_ack)
               begin
                  opcode <= fetch_data;
                  state  <= FS_EXECUTE;
               end
            FS_EXECUTE:
               state <= FS_EXEC_WAIT;
            FS_EXEC_WAIT:
               if (done)
               begin
                  pc    <= pc_next;
                  state <= FS_FETCH;
               end
            default:
               state <= FS_WAIT;
         endcase
      end
   end

endmodule

//--- rtl/cpu_isa_pkg.sv
// cornet cpu instruction set
// opcode values of the supported 6502 subset, internal operation codes,
// sequencer states and the operand word

package cpu_isa_pkg;

   localparam logic [7:0] OPC_JMP     = 8'h4C;
   localparam logic [7:0] OPC_LDY_IMM = 8'hA0;
   localparam logic [7:0] OPC_LDX_IMM = 8'hA2;
   localparam logic [7:0] OPC_LDA_ZP  = 8'hA5;
   localparam logic [7:0] OPC_LDA_IMM = 8'hA9;
   localparam logic [7:0] OPC_LDA_ABS = 8'hAD;
   localparam logic [7:0] OPC_STA_ZP  = 8'h85;
   localparam logic [7:0] OPC_STA_ABS = 8'h8D;
   localparam logic [7:0] OPC_CPY     = 8'hC0;
   localparam logic [7:0] OPC_INY     = 8'hC8;
   localparam logic [7:0] OPC_CMP     = 8'hC9;
   localparam logic [7:0] OPC_CPX     = 8'hE0;
   localparam logic [7:0] OPC_INX     = 8'hE8;
   localparam logic [7:0] OPC_BNE     = 8'hD0;
   localparam logic [7:0] OPC_BEQ     = 8'hF0;

   //////////////////////////////
   // internal operations
   localparam int OP_W = 4;

   localparam logic [OP_W-1:0] OP_NOP       = 4'd0;    // also the idle value between ops
   localparam logic [OP_W-1:0] OP_RESET     = 4'd1;
   localparam logic [OP_W-1:0] OP_JMP       = 4'd2;
   localparam logic [OP_W-1:0] OP_BRANCH    = 4'd3;
   localparam logic [OP_W-1:0] OP_NO_BRANCH = 4'd4;
   localparam logic [OP_W-1:0] OP_LDA       = 4'd5;
   localparam logic [OP_W-1:0] OP_LDX       = 4'd6;
   localparam logic [OP_W-1:0] OP_LDY       = 4'd7;
   localparam logic [OP_W-1:0] OP_LDA_MEM   = 4'd8;
   localparam logic [OP_W-1:0] OP_STA       = 4'd9;
   localparam logic [OP_W-1:0] OP_INX       = 4'd10;
   localparam logic [OP_W-1:0] OP_INY       = 4'd11;
   localparam logic [OP_W-1:0] OP_CMP       = 4'd12;
   localparam logic [OP_W-1:0] OP_CPX       = 4'd13;
   localparam logic [OP_W-1:0] OP_CPY       = 4'd14;

   //////////////////////////////
   // instruction sequencer states
   localparam int FS_W = 3;

   localparam logic [FS_W-1:0] FS_WAIT      = 3'd0;
   localparam logic [FS_W-1:0] FS_RESET     = 3'd1;
   localparam logic [FS_W-1:0] FS_FETCH     = 3'd2;
   localparam logic [FS_W-1:0] FS_LOAD      = 3'd3;
   localparam logic [FS_W-1:0] FS_EXECUTE   = 3'd4;
   localparam logic [FS_W-1:0] FS_EXEC_WAIT = 3'd5;

   typedef union packed {
      logic [cpu_bus_pkg::ADDR_W-1:0] word;       // absolute address, jump target, vector
      struct packed {
         logic [cpu_bus_pkg::DATA_W-1:0] hi;
         logic [cpu_bus_pkg::DATA_W-1:0] lo;      // immediate, zero page address or offset
      } bytes;
   } operand_u;

endpackage

//--- rtl/data_bus_if.sv
// operand channel between decode, execute and the bus unit
// carries byte and word read requests, the load read, stores and the read result

interface data_bus_if;
   import cpu_bus_pkg::*;
   import cpu_isa_pkg::*;

   logic              rd_byte;      // one cycle strobes from decode
   logic              rd_word;
   logic [ADDR_W-1:0] rd_addr;
   logic              mem_rd;       // second read of a memory load
   logic [ADDR_W-1:0] mem_addr;
   logic              wr_en;
   logic [ADDR_W-1:0] wr_addr;
   logic [DATA_W-1:0] wr_data;
   logic              ack;          // one pulse per completed read
   operand_u          operand;

   modport decode (output rd_byte, rd_word, rd_addr);

   modport execute (output mem_rd, mem_addr, wr_en, wr_addr, wr_data,
                    input ack, operand);

   modport unit (input rd_byte, rd_word, rd_addr, mem_rd, mem_addr,
                 input wr_en, wr_addr, wr_data,
                 output ack, operand);

endinterface

//--- sim/cpu_bus_checker.sv
// memory port protocol checks for the cornet cpu
// bound to the top level, flags strobe overlap, repeated strobes and address drift

module cpu_bus_checker (
   input logic                           clk,
   input logic                           reset_n,
   input logic [cpu_bus_pkg::ADDR_W-1:0] addr,
   input logic                           rd_req,
   input logic                           wr_en,
   input logic                           ready
);
   timeunit 1ns;
   timeprecision 100ps;

   int   fail_count = 0;
   logic rd_open;                 // read issued, ready not seen yet

   always_ff @(posedge clk)
   begin
      if (!reset_n)
         rd_open <= 1'b0;
      else if (rd_req)
         rd_open <= 1'b1;
      else if (ready)
         rd_open <= 1'b0;
   end

   //////////////////////////////
   // port assertions
   rd_single: assert property (@(posedge clk) disable iff (!reset_n) rd_req |=> !rd_req)
   else
   begin
      $error("rd_req high in two consecutive cycles");
      fail_count++;
   end

   rd_wr_apart: assert property (@(posedge clk) disable iff (!reset_n) !(rd_req && wr_en))
   else
   begin
      $error("rd_req and wr_en high in the same cycle");
      fail_count++;
   end

   addr_held: assert property (@(posedge clk) disable iff (!reset_n) rd_open |-> $stable(addr))
   else
   begin
      $error("addr changed while a read waits for ready");
      fail_count++;
   end

   // registers take their reset values in the first reset cycle
   quiet_in_reset: assert property (@(posedge clk)
      (!reset_n && $past(!reset_n)) |-> (!rd_req && !wr_en))
   else
   begin
      $error("memory strobe active during reset");
      fail_count++;
   end

endmodule

bind cornet_cpu cpu_bus_checker u_checker (
   .clk     (clk),
   .reset_n (reset_n),
   .addr    (addr),
   .rd_req  (rd_req),
   .wr_en   (wr_en),
   .ready   (ready)
);

//--- sim/tb_cornet_cpu.sv
// testbench for the cornet cpu
// byte wide memory model with random ready delay, small programs per test
// and memory checks once the program writes the marker address

module tb_cornet_cpu;
   timeunit 1ns;
   timeprecision 100ps;
   import cpu_isa_pkg::*;

   localparam logic [15:0] MARKER  = 16'h0200;
   localparam int          TIMEOUT = 3000;     // cycles per program

   logic        clk;
   logic        reset_n;
   logic [15:0] addr;
   logic [7:0]  rd_data;
   logic [7:0]  wr_data;
   logic        wr_en;
   logic        rd_req;
   logic        ready;

   logic [7:0]  mem [0:65535];
   int          wr_hits [logic [15:0]];        // stores seen per address
   logic [15:0] rd_log [0:2];                  // first reads after reset
   int          rd_count;
   logic        marker_hit;
   int unsigned max_delay;
   logic [31:0] rng_state = 32'd17;
   logic [15:0] load_ptr;
   int          test_errors = 0;
   int          total_errors = 0;
   int          checks = 0;
   int          tests_run = 0;

   cornet_cpu uut (
      .clk     (clk),
      .reset_n (reset_n),
      .addr    (addr),
      .rd_data (rd_data),
      .wr_data (wr_data),
      .wr_en   (wr_en),
      .rd_req  (rd_req),
      .ready   (ready)
   );

   initial
   begin : clock_gen
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [31:0] next_random();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic logic [7:0] fill_byte(input logic [15:0] a);
      return a[15:8] ^ a[7:0] ^ 8'h5A;
   endfunction

   function automatic int writes_to(input logic [15:0] a);
      return wr_hits.exists(a) ? wr_hits[a] : 0;
   endfunction

   //////////////////////////////
   // memory model
   initial
   begin : memory_model
      int          wait_cnt;
      logic [15:0] req_addr;
      wait_cnt = 0;
      req_addr = '0;
      ready    = 1'b0;
      rd_data  = 8'h00;
      forever
      begin
         @(posedge clk);
         if (!reset_n)
         begin
            wait_cnt = 0;
            rd_count = 0;
         end
         else
         begin
            if (wr_en)
            begin
               mem[addr]     = wr_data;
               wr_hits[addr] = writes_to(addr) + 1;
               if (addr == MARKER)
                  marker_hit = 1'b1;
            end
            if (rd_req)
            begin
               req_addr = addr;
               wait_cnt = 1 + int'(next_random() % max_delay);   // ready 1..max cycles later
               if (rd_count < 3)
                  rd_log[rd_count] = addr;
               rd_count++;
            end
         end
         #1;
         ready = 1'b0;
         if (wait_cnt > 0)
         begin
            wait_cnt--;
            if (wait_cnt == 0)
            begin
               ready   = 1'b1;
               rd_data = mem[req_addr];
            end
         end
      end
   end

   //////////////////////////////
   // program building
   task automatic emit(input logic [7:0] b);
      mem[load_ptr] = b;
      load_ptr++;
   endtask

   task automatic emit2(input logic [7:0] opc, input logic [7:0] b);
      emit(opc);
      emit(b);
   endtask

   task automatic emit3(input logic [7:0] opc, input logic [15:0] w);
      emit(opc);
      emit(w[7:0]);
      emit(w[15:8]);
   endtask

   // offset counts from the byte after the branch
   task automatic emit_branch(input logic [7:0] opc, input logic [15:0] target);
      emit2(opc, 8'(target - (load_ptr + 16'd2)));
   endtask

   task automatic begin_program(input logic [15:0] start);
      mem[16'hFFFC] = start[7:0];
      mem[16'hFFFD] = start[15:8];
      load_ptr      = start;
   endtask

   task automatic end_program();
      logic [15:0] here;
      emit3(OPC_STA_ABS, MARKER);
      here = load_ptr;
      emit3(OPC_JMP, here);                  // park the cpu
   endtask

   //////////////////////////////
   // test control
   task automatic hold_reset();
      @(posedge clk);
      #1;
      reset_n    = 1'b0;
      marker_hit = 1'b0;
      wr_hits.delete();
      for (int i = 0; i < 65536; i++)
         mem[i] = fill_byte(16'(i));
   endtask

   task automatic run_until_marker(input string name);
      int cycles;
      repeat (10) @(posedge clk);
      #1;
      reset_n = 1'b1;
      cycles  = 0;
      while (!marker_hit && cycles < TIMEOUT)
      begin
         @(posedge clk);
         #1;
         cycles++;
      end
      if (!marker_hit)
      begin
         $display("test %s: no write to the marker address within %0d cycles", name, TIMEOUT);
         test_errors++;
      end
   endtask

   task automatic check(input string name, input logic [15:0] expected,
                        input logic [15:0] actual);
      checks++;
      assert (actual == expected)
      else
      begin
         $display("ERROR %s: expected %h actual %h", name, expected, actual);
         test_errors++;
      end
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (test_errors == 0)
         $display("test %s: ok", name);
      else
         $display("test %s: %0d errors", name, test_errors);
      total_errors += test_errors;
      test_errors = 0;
   endtask

   //////////////////////////////
   // tests
   task automatic test_reset_vector();
      hold_reset();
      begin_program(16'h3412);
      emit2(OPC_LDA_IMM, 8'h5A);
      end_program();
      run_until_marker("reset_vector");
      check("reset_vector", 16'hFFFC, rd_log[0]);       // low byte first
      check("reset_vector", 16'hFFFD, rd_log[1]);
      check("reset_vector", 16'h3412, rd_log[2]);
      check("reset_vector", 16'h005A, mem[MARKER]);
      finish_test("reset_vector");
   endtask

   task automatic test_loads_stores();
      hold_reset();
      begin_program(16'h0800);
      emit2(OPC_LDA_IMM, 8'h3C);
      emit2(OPC_STA_ZP, 8'h10);
      emit2(OPC_LDA_IMM, 8'hC3);
      emit3(OPC_STA_ABS, 16'h0345);
      emit2(OPC_LDA_ZP, 8'h10);
      emit2(OPC_STA_ZP, 8'h11);
      emit3(OPC_LDA_ABS, 16'h0345);
      emit3(OPC_STA_ABS, 16'h0346);
      emit2(OPC_LDX_IMM, 8'h7E);
      emit2(OPC_LDY_IMM, 8'h81);
      emit2(OPC_LDA_IMM, 8'h77);
      emit2(OPC_CPX, 8'h7E);
      emit2(OPC_BNE, 8'd2);                  // store only when x holds its immediate
      emit2(OPC_STA_ZP, 8'h12);
      emit2(OPC_LDA_IMM, 8'h88);
      emit2(OPC_CPY, 8'h81);
      emit2(OPC_BNE, 8'd2);
      emit2(OPC_STA_ZP, 8'h13);
      end_program();
      run_until_marker("loads_stores");
      check("loads_stores", 16'h003C, mem[16'h0010]);
      check("loads_stores", 16'h00C3, mem[16'h0345]);
      check("loads_stores", 16'h003C, mem[16'h0011]);
      check("loads_stores", 16'h00C3, mem[16'h0346]);
      check("loads_stores", 16'h0077, mem[16'h0012]);
      check("loads_stores", 16'h0088, mem[16'h0013]);
      finish_test("loads_stores");
   endtask

   task automatic test_counted_loop(input string name);
      logic [15:0] loop_at;
      hold_reset();
      begin_program(16'h0C00);
      emit2(OPC_LDX_IMM, 8'h00);
      loop_at = load_ptr;
      emit(OPC_INX);
      emit2(OPC_STA_ZP, 8'h21);              // one store per pass
      emit2(OPC_CPX, 8'd5);
      emit_branch(OPC_BNE, loop_at);
      emit2(OPC_LDY_IMM, 8'h00);
      loop_at = load_ptr;
      emit(OPC_INY);
      emit2(OPC_STA_ZP, 8'h22);
      emit2(OPC_CPY, 8'd3);
      emit_branch(OPC_BNE, loop_at);
      end_program();
      run_until_marker(name);
      check(name, 16'd5, 16'(writes_to(16'h0021)));
      check(name, 16'd3, 16'(writes_to(16'h0022)));
      finish_test(name);
   endtask

   task automatic test_compare_branch();
      logic [7:0]  cmp_val [0:3];
      logic [7:0]  br_opc [0:3];
      logic [15:0] dest;
      logic        taken;
      cmp_val = '{8'h42, 8'h42, 8'h43, 8'h43};
      br_opc  = '{OPC_BEQ, OPC_BNE, OPC_BEQ, OPC_BNE};
      hold_reset();
      begin_program(16'h1000);
      emit2(OPC_LDA_IMM, 8'h42);
      for (int i = 0; i < 4; i++)
      begin
         emit2(OPC_CMP, cmp_val[i]);
         emit2(br_opc[i], 8'd2);             // over the two byte store
         emit2(OPC_STA_ZP, 8'h30 + 8'(i));
      end
      end_program();
      run_until_marker("compare_branch");
      for (int i = 0; i < 4; i++)
      begin
         // equal compare sets z, beq follows z and bne its inverse
         taken = (br_opc[i] == OPC_BEQ) == (cmp_val[i] == 8'h42);
         dest  = 16'h0030 + 16'(i);
         check("compare_branch", taken ? fill_byte(dest) : 8'h42, mem[dest]);
      end
      finish_test("compare_branch");
   endtask

   task automatic test_jmp();
      hold_reset();
      begin_program(16'h2000);
      emit2(OPC_LDA_IMM, 8'h99);
      emit3(OPC_JMP, load_ptr + 16'd5);      // lands past the next store
      emit2(OPC_STA_ZP, 8'h40);
      emit2(OPC_STA_ZP, 8'h41);
      end_program();
      run_until_marker("jmp");
      check("jmp", fill_byte(16'h0040), mem[16'h0040]);
      check("jmp", 16'h0099, mem[16'h0041]);
      finish_test("jmp");
   endtask

   initial
   begin : main
      reset_n   = 1'b0;
      max_delay = 1;
      test_reset_vector();
      test_loads_stores();
      test_counted_loop("counted_loop");
      test_compare_branch();
      test_jmp();
      max_delay = 4;                         // ready held off up to 4 cycles
      test_counted_loop("back_pressure");
      $display("tests %0d, checks %0d, errors %0d, bus assertion failures %0d",
               tests_run, checks, total_errors, uut.u_checker.fail_count);
      if (total_errors == 0 && uut.u_checker.fail_count == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

//--- tb.f
rtl/cpu_bus_pkg.sv
rtl/cpu_isa_pkg.sv
rtl/data_bus_if.sv
rtl/cpu_fetch.sv
rtl/cpu_decode.sv
rtl/cpu_execute.sv
rtl/bus_access.sv
rtl/cornet_cpu.sv
sim/cpu_bus_checker.sv
sim/tb_cornet_cpu.sv
